//--- alu.sv
// arithmetic logic unit
// holds the accumulator and index register, computes the operation result
// and keeps a zero flag for the accumulator
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu (
    input  logic                   clock,
    input  logic                   reset,
    alu_ctrl_if.alu                ctrl,
    input  logic [`CPU_DATA_W-1:0] idb,
    output logic [`CPU_DATA_W-1:0] result,
    output logic [`CPU_DATA_W-1:0] ixr
);

    logic [`CPU_DATA_W-1:0] acc;

    // ****************************************
    // operation unit
    // ****************************************
    // all arithmetic wraps at the word width
    always_comb begin
        case (ctrl.alu_op)
            cpu_ucode_pkg::OP_PASS: result = idb;
            cpu_ucode_pkg::OP_INC:  result = idb + 1'b1;
            cpu_ucode_pkg::OP_ADD:  result = acc + idb;
            cpu_ucode_pkg::OP_SUB:  result = acc - idb;
            cpu_ucode_pkg::OP_AND:  result = acc & idb;
            cpu_ucode_pkg::OP_XOR:  result = acc ^ idb;
            // puts acc on the bus path for a store
            cpu_ucode_pkg::OP_ACC:  result = acc;
            default:                result = idb;
        endcase
    end

    // ****************************************
    // registers
    // ****************************************
    // zero starts set because acc is cleared by reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            acc       <= '0;
            ixr       <= '0;
            ctrl.zero <= 1'b1;
        end else begin
            if (ctrl.acc_load) begin
                acc       <= result;
                ctrl.zero <= (result == '0);
            end
            // the index register loads only from an immediate via the result
            if (ctrl.ixr_load) begin
                ixr <= result;
            end
        end
    end

endmodule

//--- ccu.sv
// control sequencer
// fetches and decodes instruction bytes and steps through the micro-states,
// one per clock, driving the pcu and alu strobes
`timescale 1ns/10ps
`include "cpu_config.svh"

module ccu (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`CPU_DATA_W-1:0] tdb,
    output logic                   halted,
    pcu_ctrl_if.ccu                pctl,
    alu_ctrl_if.ccu                actl
);

    cpu_ucode_pkg::ustate_e state;
    cpu_ucode_pkg::ustate_e state_nxt;
    cpu_isa_pkg::opcode_e   ir;
    cpu_isa_pkg::opcode_e   fetched;
    // holds off the first fetch for one cycle after reset
    logic                   started;

    assign fetched = cpu_isa_pkg::opcode_e'(tdb[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB]);
    assign halted  = (state == cpu_ucode_pkg::S_HALT);

    // ir captures the opcode in S_DECODE and is used by all later states
    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= cpu_ucode_pkg::S_FETCH;
            ir      <= cpu_isa_pkg::OPC_NOP;
            started <= 1'b0;
        end else begin
            state   <= state_nxt;
            started <= 1'b1;
            if (state == cpu_ucode_pkg::S_DECODE) begin
                ir <= fetched;
            end
        end
    end

    // ****************************************
    // next state
    // ****************************************
    always_comb begin
        state_nxt = state;
        case (state)
            cpu_ucode_pkg::S_FETCH: begin
                if (started) begin
                    state_nxt = cpu_ucode_pkg::S_DECODE;
                end
            end
            // decode straight off the latch since ir only loads at the end of this state
            cpu_ucode_pkg::S_DECODE: begin
                case (fetched)
                    cpu_isa_pkg::OPC_NOP: state_nxt = cpu_ucode_pkg::S_FETCH;
                    cpu_isa_pkg::OPC_LDA, cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_SUB,
                    cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_XOR, cpu_isa_pkg::OPC_STA,
                    cpu_isa_pkg::OPC_STX, cpu_isa_pkg::OPC_LDX, cpu_isa_pkg::OPC_JMP,
                    cpu_isa_pkg::OPC_JZ:  state_nxt = cpu_ucode_pkg::S_ARG;
                    // HLT and every undefined opcode stop here
                    default:              state_nxt = cpu_ucode_pkg::S_HALT;
                endcase
            end
            cpu_ucode_pkg::S_ARG: state_nxt = cpu_ucode_pkg::S_ARG2;
            cpu_ucode_pkg::S_ARG2: begin
                if (ir == cpu_isa_pkg::OPC_LDX || ir == cpu_isa_pkg::OPC_JMP ||
                    ir == cpu_isa_pkg::OPC_JZ) begin
                    state_nxt = cpu_ucode_pkg::S_EXEC;
                end else begin
                    state_nxt = cpu_ucode_pkg::S_ADDR;
                end
            end
            cpu_ucode_pkg::S_ADDR: begin
                if (ir == cpu_isa_pkg::OPC_STA || ir == cpu_isa_pkg::OPC_STX) begin
                    state_nxt = cpu_ucode_pkg::S_PREP;
                end else begin
                    state_nxt = cpu_ucode_pkg::S_READ;
                end
            end
            cpu_ucode_pkg::S_READ:  state_nxt = cpu_ucode_pkg::S_LATCH;
            cpu_ucode_pkg::S_LATCH: state_nxt = cpu_ucode_pkg::S_EXEC;
            cpu_ucode_pkg::S_PREP:  state_nxt = cpu_ucode_pkg::S_WRITE;
            cpu_ucode_pkg::S_EXEC:  state_nxt = cpu_ucode_pkg::S_FETCH;
            cpu_ucode_pkg::S_WRITE: state_nxt = cpu_ucode_pkg::S_FETCH;
            default:                state_nxt = cpu_ucode_pkg::S_HALT;
        endcase
    end

    // ****************************************
    // strobes, each held for one state
    // ****************************************
    always_comb begin
        pctl.idb_sel   = cpu_ucode_pkg::SRC_ZERO;
        pctl.read_en   = 1'b0;
        pctl.idr_load  = 1'b0;
        pctl.tr_load   = 1'b0;
        pctl.pc_load   = 1'b0;
        pctl.addr_sel  = 1'b0;
        pctl.mem_write = 1'b0;
        actl.alu_op    = cpu_ucode_pkg::OP_PASS;
        actl.acc_load  = 1'b0;
        actl.ixr_load  = 1'b0;
        case (state)
            // instruction byte and operand byte are both read at PC
            cpu_ucode_pkg::S_FETCH: pctl.read_en = started;
            cpu_ucode_pkg::S_ARG:   pctl.read_en = 1'b1;
            cpu_ucode_pkg::S_DECODE, cpu_ucode_pkg::S_ARG2: begin
                // PC+1 through the alu, S_ARG2 also moves the operand into IDR
                pctl.idb_sel  = cpu_ucode_pkg::SRC_PC;
                actl.alu_op   = cpu_ucode_pkg::OP_INC;
                pctl.pc_load  = 1'b1;
                pctl.idr_load = (state == cpu_ucode_pkg::S_ARG2);
            end
            cpu_ucode_pkg::S_ADDR: begin
                pctl.idb_sel = cpu_ucode_pkg::SRC_IDR;
                pctl.tr_load = 1'b1;
            end
            cpu_ucode_pkg::S_READ: begin
                pctl.addr_sel = 1'b1;
                pctl.read_en  = 1'b1;
            end
            cpu_ucode_pkg::S_LATCH: pctl.idr_load = 1'b1;
            cpu_ucode_pkg::S_PREP: begin
                // read_en steers the bus into IDR, the read data itself is dropped
                pctl.idb_sel  = (ir == cpu_isa_pkg::OPC_STX) ? cpu_ucode_pkg::SRC_IXR
                                                             : cpu_ucode_pkg::SRC_ALU;
                actl.alu_op   = cpu_ucode_pkg::OP_ACC;
                pctl.addr_sel = 1'b1;
                pctl.read_en  = 1'b1;
                pctl.idr_load = 1'b1;
            end
            cpu_ucode_pkg::S_WRITE: begin
                pctl.addr_sel  = 1'b1;
                pctl.mem_write = 1'b1;
            end
            cpu_ucode_pkg::S_EXEC: begin
                pctl.idb_sel = cpu_ucode_pkg::SRC_IDR;
                case (ir)
                    cpu_isa_pkg::OPC_LDX: actl.ixr_load = 1'b1;
                    cpu_isa_pkg::OPC_JMP: pctl.pc_load  = 1'b1;
                    // only JZ ever looks at the zero flag
                    cpu_isa_pkg::OPC_JZ:  pctl.pc_load  = actl.zero;
                    cpu_isa_pkg::OPC_LDA: actl.acc_load = 1'b1;
                    cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_SUB,
                    cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_XOR: begin
                        actl.alu_op   = cpu_ucode_pkg::alu_op_e'(ir - cpu_isa_pkg::OPC_LDA + 1);
                        actl.acc_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // a halted CPU only leaves S_HALT through reset
    halt_sticky: assert property (@(posedge clock) disable iff (!reset)
        halted |=> halted);

endmodule

//--- cpu_config.svh
// CPU configuration
// word and opcode field widths and the fetch address used after reset
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// one word is both a data byte and a memory address
`define CPU_DATA_W 8

// the opcode occupies the upper nibble of an instruction byte
`define CPU_OPC_W 4

// first instruction is fetched from here once reset is released
`define CPU_RESET_PC 8'h00

`endif

//--- cpu_ctrl_if.sv
// control interfaces of the CPU
// carry the sequencer strobes to the pcu and to the alu
`timescale 1ns/10ps

// ****************************************
// ccu to pcu strobes
// ****************************************
interface pcu_ctrl_if;
    cpu_ucode_pkg::idb_src_e idb_sel;
    // read_en also picks the bus as the IDR source, otherwise IDR takes TDB
    logic read_en;
    logic idr_load;
    logic tr_load;
    logic pc_load;
    // high selects TR as the memory address instead of PC
    logic addr_sel;
    logic mem_write;

    modport ccu (output idb_sel, read_en, idr_load, tr_load, pc_load, addr_sel, mem_write);
    modport pcu (input idb_sel, read_en, idr_load, tr_load, pc_load, addr_sel, mem_write);
endinterface

// ****************************************
// ccu to alu strobes, zero flag back
// ****************************************
interface alu_ctrl_if;
    cpu_ucode_pkg::alu_op_e alu_op;
    logic acc_load;
    logic ixr_load;
    // registered in the alu and only consulted by JZ
    logic zero;

    modport ccu (output alu_op, acc_load, ixr_load, input zero);
    modport alu (input alu_op, acc_load, ixr_load, output zero);
endinterface

//--- cpu_isa_pkg.sv
// instruction set types
// opcode encodings and the position of the opcode field in an instruction byte
`include "cpu_config.svh"

package cpu_isa_pkg;

    // the opcode field is the top CPU_OPC_W bits of the instruction byte
    localparam int OPC_MSB = `CPU_DATA_W - 1;
    localparam int OPC_LSB = `CPU_DATA_W - `CPU_OPC_W;

    // the low nibble of an instruction byte carries nothing
    // encodings 4'hb to 4'he are undefined and execute as a halt
    typedef enum logic [`CPU_OPC_W-1:0] {
        OPC_NOP = 4'h0,
        OPC_LDA = 4'h1,
        OPC_ADD = 4'h2,
        OPC_SUB = 4'h3,
        OPC_AND = 4'h4,
        OPC_XOR = 4'h5,
        // stores take the address from the operand byte
        OPC_STA = 4'h6,
        OPC_STX = 4'h7,
        // immediate load of the index register
        OPC_LDX = 4'h8,
        OPC_JMP = 4'h9,
        OPC_JZ  = 4'ha,
        OPC_HLT = 4'hf
    } opcode_e;

endpackage

//--- cpu_top.sv
// CPU top level
// connects the sequencer, program control unit and alu to the memory ports
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    input  logic                   mem_error,
    output logic [`CPU_DATA_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata,
    output logic                   mem_write,
    output logic                   halted
);

    logic [`CPU_DATA_W-1:0] idb;
    logic [`CPU_DATA_W-1:0] tdb;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] ixr;

    pcu_ctrl_if pctl ();
    alu_ctrl_if actl ();

    // the write strobe leaves the chip straight from the control bundle
    assign mem_write = pctl.mem_write;

    ccu u_ccu (.clock, .reset, .tdb, .halted, .pctl(pctl.ccu), .actl(actl.ccu));

    pcu u_pcu (
        .clock, .reset, .ctrl(pctl.pcu), .alu_result, .ixr,
        .mem_rdata, .mem_error, .idb, .tdb, .mem_addr, .mem_wdata
    );

    alu u_alu (.clock, .reset, .ctrl(actl.alu), .idb, .result(alu_result), .ixr);

endmodule

//--- cpu_ucode_pkg.sv
// micro-control types
// sequencer states, internal bus sources and alu operations

package cpu_ucode_pkg;

    // one micro-state per clock cycle
    typedef enum logic [3:0] {
        S_FETCH  = 4'd0,
        S_DECODE = 4'd1,
        S_ARG    = 4'd2,
        S_ARG2   = 4'd3,
        S_ADDR   = 4'd4,
        S_READ   = 4'd5,
        S_LATCH  = 4'd6,
        S_EXEC   = 4'd7,
        S_PREP   = 4'd8,
        S_WRITE  = 4'd9,
        S_HALT   = 4'd10
    } ustate_e;

    // selects what drives the internal data bus inside the pcu
    typedef enum logic [2:0] {
        SRC_IDR  = 3'd0,
        SRC_PC   = 3'd1,
        SRC_TR   = 3'd2,
        SRC_ALU  = 3'd3,
        SRC_IXR  = 3'd4,
        SRC_ZERO = 3'd5
    } idb_src_e;

    // operation of the alu on acc and the internal data bus
    typedef enum logic [2:0] {
        OP_PASS = 3'd0,
        OP_INC  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_AND  = 3'd4,
        OP_XOR  = 3'd5,
        OP_ACC  = 3'd6
    } alu_op_e;

endpackage

//--- pcu.sv
// program control unit
// holds PC, TR, IDR and the TDB read latch, drives the internal data bus
// and presents the memory address and write data
`timescale 1ns/10ps
`include "cpu_config.svh"

module pcu (
    input  logic                   clock,
    input  logic                   reset,
    pcu_ctrl_if.pcu                ctrl,
    input  logic [`CPU_DATA_W-1:0] alu_result,
    input  logic [`CPU_DATA_W-1:0] ixr,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    input  logic                   mem_error,
    output logic [`CPU_DATA_W-1:0] idb,
    output logic [`CPU_DATA_W-1:0] tdb,
    output logic [`CPU_DATA_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata
);

    logic [`CPU_DATA_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] tr;
    logic [`CPU_DATA_W-1:0] idr;
    logic [`CPU_DATA_W-1:0] idr_src;

    // during a read IDR takes the bus, otherwise it takes the byte latched earlier
    assign idr_src = ctrl.read_en ? idb : tdb;

    // PC and TR both load from the alu, so increments and passes go through it
    always_ff @(posedge clock) begin
        if (!reset) begin
            pc  <= `CPU_RESET_PC;
            tr  <= '0;
            idr <= '0;
        end else begin
            if (ctrl.pc_load) begin
                pc <= alu_result;
            end
            if (ctrl.tr_load) begin
                tr <= alu_result;
            end
            if (ctrl.idr_load) begin
                idr <= idr_src;
            end
        end
    end

    // read latch, a failed read leaves zero behind
    always_ff @(posedge clock) begin
        if (ctrl.read_en) begin
            tdb <= mem_error ? '0 : mem_rdata;
        end
    end

    // internal data bus multiplexer
    always_comb begin
        case (ctrl.idb_sel)
            cpu_ucode_pkg::SRC_IDR: idb = idr;
            cpu_ucode_pkg::SRC_PC:  idb = pc;
            cpu_ucode_pkg::SRC_TR:  idb = tr;
            cpu_ucode_pkg::SRC_ALU: idb = alu_result;
            cpu_ucode_pkg::SRC_IXR: idb = ixr;
            default:                idb = '0;
        endcase
    end

    assign mem_addr  = ctrl.addr_sel ? tr : pc;
    assign mem_wdata = idr;

    // the sequencer never reads and writes memory in the same state
    rd_wr_excl: assert property (@(posedge clock) disable iff (!reset)
        !(ctrl.read_en && ctrl.mem_write));

    // PC and TR share the alu result, so only one of them may take it
    pc_tr_excl: assert property (@(posedge clock) disable iff (!reset)
        !(ctrl.pc_load && ctrl.tr_load));

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the CPU testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_cpu; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cpu)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- sim.f
+incdir+.
cpu_isa_pkg.sv
cpu_ucode_pkg.sv
cpu_ctrl_if.sv
pcu.sv
alu.sv
ccu.sv
cpu_top.sv
tb_cpu.sv

//--- tb_cpu.sv
// CPU testbench
// runs a table of short programs against a memory model and checks the byte
// that each program leaves at the result address
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;

    localparam int ROWS       = 9;
    localparam int PROG_BYTES = 16;
    // worst case per row is eight 8-cycle instructions plus reset
    localparam int CYCLE_LIMIT = ROWS * 80;
    localparam logic [7:0] ADDR_A   = 8'h80;
    localparam logic [7:0] ADDR_B   = 8'h81;
    localparam logic [7:0] ADDR_RES = 8'h82;
    // programs are loaded at 0 and the first fetch comes from there
    localparam logic [7:0] ADDR_START = 8'h00;

    logic                   clock = 1'b0;
    logic                   reset;
    logic [`CPU_DATA_W-1:0] mem_rdata;
    logic                   mem_error;
    logic [`CPU_DATA_W-1:0] mem_addr;
    logic [`CPU_DATA_W-1:0] mem_wdata;
    logic                   mem_write;
    logic                   halted;

    // image holds the next row's memory contents until they are copied in
    logic [7:0] mem [256] = '{default: 8'h00};
    logic [7:0] image [256];
    logic       load_en;
    logic       err_en;

    // the stimulus table has one entry per row
    string      names [ROWS];
    logic [7:0] progs [ROWS][PROG_BYTES];
    logic [7:0] op_a [ROWS];
    logic [7:0] op_b [ROWS];
    logic       errs [ROWS];
    logic [7:0] expects [ROWS];

    logic [31:0] lfsr_state = 32'h6dc8b767;
    int          asm_pc;
    int          cycles = 0;
    int          mismatches = 0;
    int          failures = 0;
    string       cur_name = "";

    always #2 clock = ~clock;

    cpu_top UUT (
        .clock, .reset, .mem_rdata, .mem_error,
        .mem_addr, .mem_wdata, .mem_write, .halted
    );

    // ****************************************
    // memory model and watchdog
    // ****************************************
    // reads are combinational, and only the first operand byte can fail
    assign mem_rdata = mem[mem_addr];
    assign mem_error = err_en && (mem_addr == ADDR_A);

    // the image is copied in while the CPU sits in reset
    always @(posedge clock) begin
        if (load_en) begin
            for (int a = 0; a < 256; a++) begin
                mem[a] <= image[a];
            end
        end else if (mem_write) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the CPU never halted in row %s within %0d cycles",
                     cur_name, CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ****************************************
    // helpers
    // ****************************************
    // right-shifting Galois LFSR that is stepped once per bit drawn
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        b = 8'h00;
        for (int k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // the background pattern outside the program makes untouched bytes easy to tell apart
    function automatic logic [7:0] fill_byte(input logic [7:0] addr);
        return addr ^ 8'h5c;
    endfunction

    // acc combined with the memory operand wraps at 256
    function automatic logic [7:0] alu_expect(input cpu_isa_pkg::opcode_e op,
                                              input logic [7:0] a, input logic [7:0] b);
        case (op)
            cpu_isa_pkg::OPC_ADD: return a + b;
            cpu_isa_pkg::OPC_SUB: return a - b;
            cpu_isa_pkg::OPC_AND: return a & b;
            cpu_isa_pkg::OPC_XOR: return a ^ b;
            default:              return b;
        endcase
    endfunction

    task automatic start_row(input int row, input string name, input logic [7:0] a,
                             input logic [7:0] b, input logic err, input logic [7:0] exp);
        names[row]   = name;
        op_a[row]    = a;
        op_b[row]    = b;
        errs[row]    = err;
        expects[row] = exp;
        asm_pc       = 0;
        for (int k = 0; k < PROG_BYTES; k++) begin
            progs[row][k] = 8'h00;
        end
    endtask

    // NOP and HLT take one byte and every other opcode is followed by its operand
    task automatic emit(input int row, input cpu_isa_pkg::opcode_e op, input logic [7:0] arg);
        progs[row][asm_pc] = {op, 4'h0};
        if (op == cpu_isa_pkg::OPC_NOP || op == cpu_isa_pkg::OPC_HLT) begin
            asm_pc = asm_pc + 1;
        end else begin
            progs[row][asm_pc + 1] = arg;
            asm_pc = asm_pc + 2;
        end
    endtask

    // the taken path lands on SUB at 0a while the other path stores and jumps over the 0c store
    task automatic emit_branch_program(input int row);
        emit(row, cpu_isa_pkg::OPC_LDA, ADDR_A);
        emit(row, cpu_isa_pkg::OPC_JZ, 8'h0a);
        emit(row, cpu_isa_pkg::OPC_LDA, ADDR_B);
        emit(row, cpu_isa_pkg::OPC_STA, ADDR_RES);
        emit(row, cpu_isa_pkg::OPC_JMP, 8'h0e);
        emit(row, cpu_isa_pkg::OPC_SUB, ADDR_B);
        emit(row, cpu_isa_pkg::OPC_STA, ADDR_RES);
        emit(row, cpu_isa_pkg::OPC_HLT, 8'h00);
    endtask

    task automatic build_table();
        cpu_isa_pkg::opcode_e alu_ops [4];
        string                alu_names [4];
        logic [7:0]           a;
        logic [7:0]           b;
        alu_ops   = '{cpu_isa_pkg::OPC_ADD, cpu_isa_pkg::OPC_SUB,
                      cpu_isa_pkg::OPC_AND, cpu_isa_pkg::OPC_XOR};
        alu_names = '{"add_random", "sub_random", "and_random", "xor_random"};
        for (int k = 0; k < 4; k++) begin
            draw_byte(a);
            draw_byte(b);
            start_row(k, alu_names[k], a, b, 1'b0, alu_expect(alu_ops[k], a, b));
            emit(k, cpu_isa_pkg::OPC_LDA, ADDR_A);
            emit(k, alu_ops[k], ADDR_B);
            emit(k, cpu_isa_pkg::OPC_STA, ADDR_RES);
            emit(k, cpu_isa_pkg::OPC_HLT, 8'h00);
        end
        start_row(4, "ldx_stx", 8'h00, 8'h00, 1'b0, 8'hc3);
        emit(4, cpu_isa_pkg::OPC_LDX, 8'hc3);
        emit(4, cpu_isa_pkg::OPC_STX, ADDR_RES);
        emit(4, cpu_isa_pkg::OPC_HLT, 8'h00);
        // a zero first operand takes the branch and stores 0 minus the marker
        start_row(5, "jz_taken", 8'h00, 8'h5a, 1'b0,
                  alu_expect(cpu_isa_pkg::OPC_SUB, 8'h00, 8'h5a));
        emit_branch_program(5);
        start_row(6, "jz_not_taken", 8'h33, 8'h5a, 1'b0, 8'h5a);
        emit_branch_program(6);
        // the failed read leaves zero in the acc
        start_row(7, "lda_mem_error", 8'h7e, 8'h00, 1'b1, 8'h00);
        emit(7, cpu_isa_pkg::OPC_LDA, ADDR_A);
        emit(7, cpu_isa_pkg::OPC_STA, ADDR_RES);
        emit(7, cpu_isa_pkg::OPC_HLT, 8'h00);
        start_row(8, "hlt_only", 8'h00, 8'h00, 1'b0, fill_byte(ADDR_RES));
        emit(8, cpu_isa_pkg::OPC_HLT, 8'h00);
    endtask

    // ****************************************
    // row runner
    // ****************************************
    task automatic run_row(input int row);
        cur_name = names[row];
        for (int k = 0; k < 256; k++) begin
            image[k] = fill_byte(k[7:0]);
        end
        for (int k = 0; k < PROG_BYTES; k++) begin
            image[k] = progs[row][k];
        end
        image[ADDR_A] = op_a[row];
        image[ADDR_B] = op_b[row];
        // reset is seen on three edges and the image goes in on the first of them
        @(posedge clock);
        reset   <= 1'b0;
        load_en <= 1'b1;
        err_en  <= errs[row];
        @(posedge clock);
        load_en <= 1'b0;
        repeat (2) @(posedge clock);
        reset <= 1'b1;
        // outputs are sampled on the falling edge half a cycle after they settle
        @(negedge clock);
        assert (!mem_write && !halted) else begin
            $display("row %s: mem_write or halted is high right after reset", cur_name);
            failures++;
        end
        assert (mem_addr == ADDR_START) else begin
            $display("MISMATCH %s first address: expected %02h, actual %02h",
                     cur_name, ADDR_START, mem_addr);
            mismatches++;
        end
        while (!halted) begin
            @(negedge clock);
        end
        assert (mem[ADDR_RES] == expects[row]) else begin
            $display("MISMATCH %s: expected %02h, actual %02h",
                     cur_name, expects[row], mem[ADDR_RES]);
            mismatches++;
        end
    endtask

    initial begin
        reset   = 1'b0;
        load_en = 1'b0;
        err_en  = 1'b0;
        build_table();
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
